// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_top
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(BUILD)

// File: hw/egress_arbiter.sv
// round-robin read arbiter with one output holding slot per queue
`include "sram_fifo_cfg.svh"

module egress_arbiter (
    input  logic                                    clk,
    input  logic                                    memreset,
    input  queue_pkg::qmask_t                       q_empty,
    input  stream_pkg::mem_word_t                   rd_word,
    input  queue_pkg::qmask_t                       m_tready,
    output logic                                    rd_en,
    output queue_pkg::qid_t                         rd_queue,
    output queue_pkg::qmask_t                       m_tvalid,
    output stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  m_tdata,
    output queue_pkg::qmask_t                       m_tlast
);

    queue_pkg::slot_state_t slot_state [`SF_NUM_QUEUES];
    stream_pkg::mem_word_t  slot_word [`SF_NUM_QUEUES];

    queue_pkg::qid_t   last_grant;
    queue_pkg::qid_t   pick;
    queue_pkg::qid_t   scan;
    logic              found;
    queue_pkg::qmask_t can_take;
    queue_pkg::qmask_t candidate;

    // read issued last cycle, its word is on rd_word now
    logic              land_valid;
    queue_pkg::qid_t   land_queue;

    //////////////////////////////
    // read request selection
    //////////////////////////////

    // slot free now, or emptied by the output this very cycle
    always_comb
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            can_take[q] = (slot_state[q] == queue_pkg::slot_empty) ||
                          ((slot_state[q] == queue_pkg::slot_full) && m_tready[q]);
        end
    end

    assign candidate = ~q_empty & can_take;

    always_comb
    begin
        found = 1'b0;
        pick  = last_grant;
        scan  = last_grant;
        for (int i = 1; i <= `SF_NUM_QUEUES; i++)
        begin
            scan = queue_pkg::qid_t'((int'(last_grant) + i) % `SF_NUM_QUEUES);
            if (!found && candidate[scan])
            begin
                found = 1'b1;
                pick  = scan;
            end
        end
    end

    assign rd_en    = found;
    assign rd_queue = pick;

    //////////////////////////////
    // slot state machines
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            last_grant <= queue_pkg::qid_t'(`SF_NUM_QUEUES - 1);
            land_valid <= 1'b0;
            land_queue <= '0;
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                slot_state[q] <= queue_pkg::slot_empty;
            end
        end
        else
        begin
            land_valid <= rd_en;
            land_queue <= rd_queue;
            if (rd_en)
            begin
                last_grant <= rd_queue;
            end
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (land_valid && (land_queue == queue_pkg::qid_t'(q)))
                begin
                    slot_state[q] <= queue_pkg::slot_full;
                end
                else if (rd_en && (rd_queue == queue_pkg::qid_t'(q)))
                begin
                    // a new read wins over the drain in the same cycle
                    slot_state[q] <= queue_pkg::slot_pending;
                end
                else if ((slot_state[q] == queue_pkg::slot_full) && m_tready[q])
                begin
                    slot_state[q] <= queue_pkg::slot_empty;
                end
            end
        end
    end

    // returning word goes to the queue remembered from the read
    always_ff @(posedge clk)
    begin
        if (land_valid)
        begin
            slot_word[land_queue] <= rd_word;
        end
    end

    //////////////////////////////
    // output streams
    //////////////////////////////

    always_comb
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            m_tvalid[q] = (slot_state[q] == queue_pkg::slot_full);
            m_tdata[q]  = slot_word[q][`SF_DATA_WIDTH-1:0];
            m_tlast[q]  = slot_word[q][`SF_DATA_WIDTH];
        end
    end

endmodule

// File: hw/ingress_arbiter.sv
// round-robin write arbiter from the input streams into the queue memory
`include "sram_fifo_cfg.svh"

module ingress_arbiter (
    input  logic                                    clk,
    input  logic                                    memreset,
    input  queue_pkg::qmask_t                       s_tvalid,
    input  stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  s_tdata,
    input  queue_pkg::qmask_t                       s_tlast,
    input  queue_pkg::qmask_t                       q_full,
    output queue_pkg::qmask_t                       s_tready,
    output logic                                    wr_en,
    output queue_pkg::qid_t                         wr_queue,
    output stream_pkg::mem_word_t                   wr_word
);

    queue_pkg::qid_t last_grant;
    queue_pkg::qid_t pick;
    queue_pkg::qid_t scan;
    logic            found;
    // low until the first clock after reset has passed
    logic            armed;

    //////////////////////////////
    // round-robin search
    //////////////////////////////

    // start one past the last winner
    always_comb
    begin
        found = 1'b0;
        pick  = last_grant;
        scan  = last_grant;
        for (int i = 1; i <= `SF_NUM_QUEUES; i++)
        begin
            scan = queue_pkg::qid_t'((int'(last_grant) + i) % `SF_NUM_QUEUES);
            if (!found && s_tvalid[scan] && !q_full[scan])
            begin
                found = 1'b1;
                pick  = scan;
            end
        end
    end

    assign wr_en    = found && armed;
    assign wr_queue = pick;
    assign wr_word  = {s_tlast[pick], s_tdata[pick]};

    // ready only towards the winner
    always_comb
    begin
        s_tready = '0;
        s_tready[pick] = wr_en;
    end

    //////////////////////////////
    // grant history
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            armed      <= 1'b0;
            last_grant <= queue_pkg::qid_t'(`SF_NUM_QUEUES - 1);
        end
        else
        begin
            armed <= 1'b1;
            // only a real transfer moves the pointer
            if (wr_en)
            begin
                last_grant <= pick;
            end
        end
    end

endmodule

// File: hw/queue_memory.sv
// shared storage array with per-queue pointers, occupancy, full and empty
`include "sram_fifo_cfg.svh"

module queue_memory (
    input  logic                  clk,
    input  logic                  memreset,
    input  logic                  wr_en,
    input  queue_pkg::qid_t       wr_queue,
    input  stream_pkg::mem_word_t wr_word,
    input  logic                  rd_en,
    input  queue_pkg::qid_t       rd_queue,
    output stream_pkg::mem_word_t rd_word,
    output queue_pkg::qmask_t     q_full,
    output queue_pkg::qmask_t     q_empty
);

    // one region of depth words per queue
    stream_pkg::mem_word_t storage [`SF_MEM_WORDS];

    queue_pkg::ptr_t   wr_ptr [`SF_NUM_QUEUES];
    queue_pkg::ptr_t   rd_ptr [`SF_NUM_QUEUES];
    queue_pkg::count_t count  [`SF_NUM_QUEUES];

    logic [`SF_ADDR_WIDTH-1:0] wr_addr;
    logic [`SF_ADDR_WIDTH-1:0] rd_addr;
    queue_pkg::qmask_t         wr_hit;
    queue_pkg::qmask_t         rd_hit;

    // queue number selects the region, pointer the word in it
    assign wr_addr = {wr_queue, wr_ptr[wr_queue]};
    assign rd_addr = {rd_queue, rd_ptr[rd_queue]};

    always_comb
    begin
        wr_hit = '0;
        rd_hit = '0;
        wr_hit[wr_queue] = wr_en;
        rd_hit[rd_queue] = rd_en;
    end

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            storage[wr_addr] <= wr_word;
        end
        // registered read, one cycle latency
        if (rd_en)
        begin
            rd_word <= storage[rd_addr];
        end
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk)
    begin
        if (memreset)
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end
        else
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                // pointers wrap inside the region
                if (wr_hit[q])
                begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (rd_hit[q])
                begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                // write and read together leave the count alone
                if (wr_hit[q] && !rd_hit[q])
                begin
                    count[q] <= count[q] + 1'b1;
                end
                else if (rd_hit[q] && !wr_hit[q])
                begin
                    count[q] <= count[q] - 1'b1;
                end
            end
        end
    end

    always_comb
    begin
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            q_full[q]  = (count[q] == queue_pkg::count_t'(`SF_QUEUE_DEPTH));
            q_empty[q] = (count[q] == '0);
        end
    end

endmodule

// File: hw/queue_pkg.sv
// queue number, mask, pointer, occupancy and output slot state types
`include "sram_fifo_cfg.svh"

package queue_pkg;

    // queue number
    typedef logic [`SF_QID_WIDTH-1:0] qid_t;

    // one bit per queue, indexed by queue number
    typedef logic [`SF_NUM_QUEUES-1:0] qmask_t;

    // index inside one queue region
    typedef logic [`SF_PTR_WIDTH-1:0] ptr_t;

    // words held by one queue, 0 up to the depth
    typedef logic [`SF_COUNT_WIDTH-1:0] count_t;

    // output holding slot
    typedef enum logic [1:0] {
        slot_empty,
        slot_pending,
        slot_full
    } slot_state_t;

endpackage

// File: hw/sram_fifo_cfg.svh
// queue count, beat width, queue depth and the widths derived from them
`ifndef SRAM_FIFO_CFG_SVH
`define SRAM_FIFO_CFG_SVH

//////////////////////////////
// base sizes
//////////////////////////////

`define SF_NUM_QUEUES 4
`define SF_DATA_WIDTH 32
`define SF_QUEUE_DEPTH 16

//////////////////////////////
// derived widths
//////////////////////////////

`define SF_QID_WIDTH 2
`define SF_PTR_WIDTH 4
// one extra bit so a count can reach the full depth
`define SF_COUNT_WIDTH (`SF_PTR_WIDTH + 1)
`define SF_WORD_WIDTH (`SF_DATA_WIDTH + 1)
`define SF_ADDR_WIDTH (`SF_QID_WIDTH + `SF_PTR_WIDTH)
`define SF_MEM_WORDS (`SF_NUM_QUEUES * `SF_QUEUE_DEPTH)

`endif

// File: hw/sram_fifo_top.sv
// top level joining the ingress and egress arbiters to the shared queue memory
`include "sram_fifo_cfg.svh"

module sram_fifo_top (
    input  logic                                    clk,
    input  logic                                    memreset,

    // input streams
    input  queue_pkg::qmask_t                       s_tvalid,
    output queue_pkg::qmask_t                       s_tready,
    input  stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  s_tdata,
    input  queue_pkg::qmask_t                       s_tlast,

    // output streams
    output queue_pkg::qmask_t                       m_tvalid,
    input  queue_pkg::qmask_t                       m_tready,
    output stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  m_tdata,
    output queue_pkg::qmask_t                       m_tlast
);

    // write side
    logic                  wr_en;
    queue_pkg::qid_t       wr_queue;
    stream_pkg::mem_word_t wr_word;

    // read side
    logic                  rd_en;
    queue_pkg::qid_t       rd_queue;
    stream_pkg::mem_word_t rd_word;

    // queue status back to both arbiters
    queue_pkg::qmask_t     q_full;
    queue_pkg::qmask_t     q_empty;

    ingress_arbiter u_ingress (
        .clk      (clk),
        .memreset (memreset),
        .s_tvalid (s_tvalid),
        .s_tdata  (s_tdata),
        .s_tlast  (s_tlast),
        .q_full   (q_full),
        .s_tready (s_tready),
        .wr_en    (wr_en),
        .wr_queue (wr_queue),
        .wr_word  (wr_word)
    );

    queue_memory u_memory (
        .clk      (clk),
        .memreset (memreset),
        .wr_en    (wr_en),
        .wr_queue (wr_queue),
        .wr_word  (wr_word),
        .rd_en    (rd_en),
        .rd_queue (rd_queue),
        .rd_word  (rd_word),
        .q_full   (q_full),
        .q_empty  (q_empty)
    );

    egress_arbiter u_egress (
        .clk      (clk),
        .memreset (memreset),
        .q_empty  (q_empty),
        .rd_word  (rd_word),
        .m_tready (m_tready),
        .rd_en    (rd_en),
        .rd_queue (rd_queue),
        .m_tvalid (m_tvalid),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast)
    );

endmodule

// File: hw/stream_pkg.sv
// stream beat data type and stored memory word type
`include "sram_fifo_cfg.svh"

package stream_pkg;

    // data carried by one beat
    typedef logic [`SF_DATA_WIDTH-1:0] data_t;

    // last flag in the top bit, beat data below it
    typedef logic [`SF_WORD_WIDTH-1:0] mem_word_t;

endpackage

// File: sources.f
+incdir+hw
hw/stream_pkg.sv
hw/queue_pkg.sv
hw/ingress_arbiter.sv
hw/egress_arbiter.sv
hw/queue_memory.sv
hw/sram_fifo_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: tests/tb_checker.sv
// reference model per queue and checks on every beat and ready rule
`include "sram_fifo_cfg.svh"

module tb_checker (
    input  logic                                    clk,
    input  logic                                    memreset,
    input  queue_pkg::qmask_t                       s_tvalid,
    input  queue_pkg::qmask_t                       s_tready,
    input  stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  s_tdata,
    input  queue_pkg::qmask_t                       s_tlast,
    input  queue_pkg::qmask_t                       m_tvalid,
    input  queue_pkg::qmask_t                       m_tready,
    input  stream_pkg::data_t [`SF_NUM_QUEUES-1:0]  m_tdata,
    input  queue_pkg::qmask_t                       m_tlast,
    input  int                                      test_id,
    input  logic                                    test_end,
    input  int                                      exp_total,
    output int                                      error_count,
    output int                                      tests_passed,
    output int                                      tests_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    // beats accepted at the inputs and not yet seen at the outputs
    stream_pkg::mem_word_t model [`SF_NUM_QUEUES][$];
    int                    accepted [`SF_NUM_QUEUES];
    int                    errors_before;
    int                    reset_edges;
    logic                  after_reset;
    queue_pkg::qmask_t     stalled;

    task automatic report_error(input string msg);
        begin
            error_count++;
            $display("%s at %0t", msg, $time);
        end
    endtask

    // outputs stay quiet in reset and one cycle beyond
    task automatic check_idle();
        begin
            if (m_tvalid !== queue_pkg::qmask_t'(0))
                report_error($sformatf("Error: m_tvalid expected %h got %h",
                                       queue_pkg::qmask_t'(0), m_tvalid));
            if (s_tready !== queue_pkg::qmask_t'(0))
                report_error($sformatf("Error: s_tready expected %h got %h",
                                       queue_pkg::qmask_t'(0), s_tready));
        end
    endtask

    task automatic compare_beat(input int q);
        stream_pkg::mem_word_t exp_word;
        begin
            if (model[q].size() == 0)
            begin
                report_error($sformatf("output %0d delivered a beat that was never sent", q));
            end
            else
            begin
                exp_word = model[q].pop_front();
                if (m_tdata[q] !== exp_word[`SF_DATA_WIDTH-1:0])
                    report_error($sformatf("Error: m_tdata[%0d] expected %h got %h",
                                           q, exp_word[`SF_DATA_WIDTH-1:0], m_tdata[q]));
                if (m_tlast[q] !== exp_word[`SF_DATA_WIDTH])
                    report_error($sformatf("Error: m_tlast[%0d] expected %h got %h",
                                           q, exp_word[`SF_DATA_WIDTH], m_tlast[q]));
            end
        end
    endtask

    //////////////////////////////
    // per-edge checks
    //////////////////////////////

    task automatic check_edge();
        int lo;
        int hi;
        begin
            if ($countones(s_tready) > 1)
                report_error($sformatf("s_tready high for several queues at once (%h)", s_tready));
            lo = 0;
            hi = 0;
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (stalled[q] && !m_tvalid[q])
                    report_error($sformatf("m_tvalid[%0d] dropped before its beat was taken", q));
                // depth words in memory plus one in the slot
                if (s_tready[q] && model[q].size() > `SF_QUEUE_DEPTH)
                    report_error($sformatf("s_tready[%0d] high while the queue is full", q));
                if (test_id == 2 && q != 0 && m_tvalid[q])
                    report_error($sformatf("output %0d active in the single-queue test", q));
                if (m_tvalid[q] && m_tready[q])
                    compare_beat(q);
                if (s_tvalid[q] && s_tready[q])
                begin
                    model[q].push_back({s_tlast[q], s_tdata[q]});
                    accepted[q]++;
                end
                lo = (q == 0 || accepted[q] < lo) ? accepted[q] : lo;
                hi = (q == 0 || accepted[q] > hi) ? accepted[q] : hi;
            end
            stalled = m_tvalid & ~m_tready;
            if (test_id == 5 && hi - lo > 1)
                report_error($sformatf("accepted counts differ by %0d in the fairness test",
                                       hi - lo));
        end
    endtask

    task automatic finish_test();
        int total;
        begin
            total = 0;
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                if (model[q].size() != 0)
                    report_error($sformatf("queue %0d lost %0d beats", q, model[q].size()));
                total += accepted[q];
                accepted[q] = 0;
            end
            if (total != exp_total)
                report_error($sformatf("%0d beats accepted where %0d were expected",
                                       total, exp_total));
            if (error_count == errors_before)
            begin
                tests_passed++;
                $display("test %0d passed", test_id);
            end
            else
            begin
                tests_failed++;
                $display("test %0d failed with %0d errors", test_id, error_count - errors_before);
            end
            errors_before = error_count;
        end
    endtask

    always @(posedge clk)
    begin
        if (memreset)
        begin
            // nothing is known before the first reset edge
            if (reset_edges > 0)
                check_idle();
            reset_edges++;
            after_reset = 1'b1;
            stalled = '0;
        end
        else
        begin
            if (after_reset)
                check_idle();
            after_reset = 1'b0;
            check_edge();
        end
        if (test_end)
            finish_test();
    end

endmodule

// File: tests/tb_top.sv
// clock, reset, seeded random stimulus, test sequence and timeout
`include "sram_fifo_cfg.svh"

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    // beats offered over all tests, sizes the timeout
    localparam int planned_beats = `SF_NUM_QUEUES + 40 + 300 + 60 + 80;
    localparam int cycle_limit = planned_beats * 8 + 500;

    logic                                   clk = 1'b0;
    logic                                   memreset;
    queue_pkg::qmask_t                      s_tvalid;
    queue_pkg::qmask_t                      s_tready;
    stream_pkg::data_t [`SF_NUM_QUEUES-1:0] s_tdata;
    queue_pkg::qmask_t                      s_tlast;
    queue_pkg::qmask_t                      m_tvalid;
    queue_pkg::qmask_t                      m_tready;
    stream_pkg::data_t [`SF_NUM_QUEUES-1:0] m_tdata;
    queue_pkg::qmask_t                      m_tlast;

    int                test_id;
    logic              test_end;
    int                exp_total;
    int                error_count;
    int                tests_passed;
    int                tests_failed;
    int                seed = 32'hd1fc;
    int                budget [`SF_NUM_QUEUES];
    queue_pkg::qmask_t in_acc;
    int                sent_total;
    int                recv_total;
    int                cycle_count;

    sram_fifo_top dut0 (.*);
    tb_checker chk0 (.*);

    always #5 clk = ~clk;

    // transfer tracking for the drain wait, plus the run limit
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        in_acc      <= s_tvalid & s_tready;
        sent_total  <= sent_total + $countones(s_tvalid & s_tready);
        recv_total  <= recv_total + $countones(m_tvalid & m_tready);
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout, traffic did not finish within %0d cycles", cycle_count);
            $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // a source keeps its beat until it is taken
    task automatic drive_inputs(input logic gaps, input logic rand_ready,
                                input queue_pkg::qmask_t hold_low);
        logic [31:0] rnd;
        begin
            for (int q = 0; q < `SF_NUM_QUEUES; q++)
            begin
                rnd = $random(seed);
                m_tready[q] = (rnd[2] || !rand_ready) && !hold_low[q];
                if (!s_tvalid[q] || in_acc[q])
                begin
                    s_tvalid[q] = (budget[q] > 0) && (rnd[0] || !gaps);
                    s_tlast[q]  = rnd[1];
                    s_tdata[q]  = $random(seed);
                    if (s_tvalid[q])
                        budget[q]--;
                end
            end
        end
    endtask

    // runs until every budget is spent and every beat came out
    task automatic run_traffic(input logic gaps, input logic rand_ready);
        begin
            do
            begin
                @(negedge clk);
                drive_inputs(gaps, rand_ready, '0);
            end
            while (s_tvalid != '0 || budget.sum() != 0 || recv_total != sent_total);
        end
    endtask

    task automatic end_test(input int next_id, input int next_total);
        begin
            @(negedge clk);
            test_end = 1'b1;
            @(negedge clk);
            test_end  = 1'b0;
            test_id   = next_id;
            exp_total = next_total;
        end
    endtask

    initial
    begin
        // every input offers a beat through reset, none may be taken yet
        memreset  = 1'b1;
        s_tvalid  = '1;
        s_tlast   = queue_pkg::qmask_t'($random(seed));
        for (int q = 0; q < `SF_NUM_QUEUES; q++)
        begin
            s_tdata[q] = $random(seed);
        end
        m_tready  = '0;
        test_id   = 1;
        test_end  = 1'b0;
        exp_total = `SF_NUM_QUEUES;
        repeat (4) @(posedge clk);
        @(negedge clk);
        memreset = 1'b0;
        // the held beats go through once reset is over
        run_traffic(1'b0, 1'b0);
        end_test(2, 40);
        budget[0] = 40;
        run_traffic(1'b0, 1'b0);
        end_test(3, 300);
        // all queues, random gaps and random back-pressure
        budget = '{default: 75};
        run_traffic(1'b1, 1'b1);
        end_test(4, 17);
        // output 2 blocked while input 2 keeps offering
        budget[2] = 60;
        repeat (60)
        begin
            @(negedge clk);
            drive_inputs(1'b0, 1'b0, 4'b0100);
        end
        // source withdraws its last offer, then output 2 drains
        @(negedge clk);
        s_tvalid  = '0;
        budget[2] = 0;
        run_traffic(1'b0, 1'b0);
        end_test(5, 80);
        budget = '{default: 20};
        run_traffic(1'b0, 1'b0);
        end_test(0, 0);
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && error_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule
